// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= simd_alu_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/alu_control.sv ====
`timescale 1ns/10ps

module alu_control
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input simd_alu_pkg::alu_op_e op,
	input logic is_signed,
	output simd_alu_pkg::result_sel_e sel,
	output logic load,
	output logic done
);

	// opcode to result source
	always_comb
	begin
		case (op)
		simd_alu_pkg::op_add: sel = simd_alu_pkg::sel_sum;
		simd_alu_pkg::op_sub: sel = simd_alu_pkg::sel_diff;
		simd_alu_pkg::op_slt:
		begin
			if (is_signed)
				sel = simd_alu_pkg::sel_lts;
			else
				sel = simd_alu_pkg::sel_ltu;
		end
		simd_alu_pkg::op_and: sel = simd_alu_pkg::sel_and;
		simd_alu_pkg::op_orr: sel = simd_alu_pkg::sel_orr;
		simd_alu_pkg::op_xor: sel = simd_alu_pkg::sel_xor;
		simd_alu_pkg::op_shl: sel = simd_alu_pkg::sel_shl;
		simd_alu_pkg::op_shr:
		begin
			// signed shift right is the arithmetic one
			if (is_signed)
				sel = simd_alu_pkg::sel_asr;
			else
				sel = simd_alu_pkg::sel_lsr;
		end
		simd_alu_pkg::op_inv: sel = simd_alu_pkg::sel_inv;
		simd_alu_pkg::op_not: sel = simd_alu_pkg::sel_not;
		default: sel = simd_alu_pkg::sel_zero;
		endcase
	end

	// result register takes the answer on the start edge
	assign load = start;

	// done lines up with the result being visible
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= start;
	end

endmodule

// ==== source/lane_adder.sv ====
`timescale 1ns/10ps

module lane_adder
(
	input simd_alu_pkg::word_t a,
	input simd_alu_pkg::word_t b,
	input simd_alu_pkg::lane_size_e size,
	output simd_alu_pkg::word_t sum,
	output simd_alu_pkg::word_t diff,
	output simd_alu_pkg::lane_flags_t ltu_flags,
	output simd_alu_pkg::lane_flags_t lts_flags
);

	simd_alu_pkg::word_t low_mask;
	simd_alu_pkg::word_t top_bits;
	simd_alu_pkg::word_t lane_lsbs;
	simd_alu_pkg::word_t inv_b;
	simd_alu_pkg::word_t diff_raw;
	simd_alu_pkg::word_t ltu_top;
	simd_alu_pkg::word_t lts_top;

	// moves each lane's top-bit value down to the lane's lowest byte
	function automatic simd_alu_pkg::lane_flags_t pick_flags
	(
		simd_alu_pkg::word_t top_vals,
		simd_alu_pkg::lane_size_e lane_size
	);
		simd_alu_pkg::word_t shifted;
		simd_alu_pkg::lane_flags_t flags;
		int lane_bytes;
		lane_bytes = 1 << lane_size;
		shifted = top_vals >> (8 * (lane_bytes - 1));
		for (int i = 0; i < 8; i++)
			flags[i] = shifted[8 * i + 7] && ((i % lane_bytes) == 0);
		return flags;
	endfunction

	assign low_mask = simd_alu_pkg::lane_low_mask(size);
	assign top_bits = ~low_mask;

	// rotating the top bits left by one marks each lane's bit 0
	assign lane_lsbs = {top_bits[62:0], top_bits[63]};
	assign inv_b = ~b;

	// low bits add freely, the top bit of a lane is patched by xor
	assign sum = ((a & low_mask) + (b & low_mask)) ^ ((a ^ b) & top_bits);

	// a + ~b + 1 per lane, the +1 can never reach the top bit
	assign diff_raw = (a & low_mask) + (inv_b & low_mask) + lane_lsbs;
	assign diff = diff_raw ^ ((a ^ inv_b) & top_bits);

	// diff_raw top bits hold the carry into each lane's top bit
	// no carry out of the lane means a borrow, so a < b
	assign ltu_top = ~((a & inv_b) | ((a ^ inv_b) & diff_raw)) & top_bits;

	// signs differ: a negative wins. signs equal: sign of difference
	assign lts_top = ((a & ~b) | (~(a ^ b) & diff)) & top_bits;

	assign ltu_flags = pick_flags(ltu_top, size);
	assign lts_flags = pick_flags(lts_top, size);

endmodule

// ==== source/lane_shifter.sv ====
`timescale 1ns/10ps

module lane_shifter
(
	input simd_alu_pkg::word_t a,
	input simd_alu_pkg::word_t b,
	input simd_alu_pkg::lane_size_e size,
	output simd_alu_pkg::word_t shl,
	output simd_alu_pkg::word_t lsr,
	output simd_alu_pkg::word_t asr
);

	// one full word of results per lane size, indexed by size
	simd_alu_pkg::word_t [3:0] shl_set;
	simd_alu_pkg::word_t [3:0] lsr_set;
	simd_alu_pkg::word_t [3:0] asr_set;

	// s = 0..3 gives lanes of 8, 16, 32 and 64 bits
	for (genvar s = 0; s < 4; s++)
	begin : g_size
		localparam int LANE_W = 8 << s;

		for (genvar i = 0; i < 64 / LANE_W; i++)
		begin : g_lane
			logic [LANE_W-1:0] lane_a;
			logic [LANE_W-1:0] lane_amt;

			assign lane_a = a[LANE_W*i +: LANE_W];
			// the whole b lane is the amount, taken unsigned
			assign lane_amt = b[LANE_W*i +: LANE_W];

			// amounts at or past the lane width flush to zero
			assign shl_set[s][LANE_W*i +: LANE_W] = lane_a << lane_amt;
			assign lsr_set[s][LANE_W*i +: LANE_W] = lane_a >> lane_amt;

			// large amounts leave the lane full of its sign bit
			assign asr_set[s][LANE_W*i +: LANE_W] = $signed(lane_a) >>> lane_amt;
		end
	end

	assign shl = shl_set[size];
	assign lsr = lsr_set[size];
	assign asr = asr_set[size];

endmodule

// ==== source/result_select.sv ====
`timescale 1ns/10ps

module result_select
(
	input logic clk,
	input logic rst_n,
	input logic load,
	input simd_alu_pkg::result_sel_e sel,
	input simd_alu_pkg::lane_size_e size,
	input simd_alu_pkg::word_t a,
	input simd_alu_pkg::word_t b,
	input simd_alu_pkg::word_t sum,
	input simd_alu_pkg::word_t diff,
	input simd_alu_pkg::lane_flags_t ltu_flags,
	input simd_alu_pkg::lane_flags_t lts_flags,
	input simd_alu_pkg::word_t shl,
	input simd_alu_pkg::word_t lsr,
	input simd_alu_pkg::word_t asr,
	output simd_alu_pkg::word_t result
);

	simd_alu_pkg::lane_flags_t zero_flags;
	simd_alu_pkg::word_t next_result;

	// flag of each lane becomes 1 or 0 in the whole lane
	function automatic simd_alu_pkg::word_t expand_flags
	(
		simd_alu_pkg::lane_flags_t flags,
		simd_alu_pkg::lane_size_e lane_size
	);
		simd_alu_pkg::word_t lanes;
		int lane_bytes;
		lane_bytes = 1 << lane_size;
		lanes = '0;
		for (int i = 0; i < 8; i++)
			lanes[8 * i] = flags[i] && ((i % lane_bytes) == 0);
		return lanes;
	endfunction

	// a lane of a is zero when none of its bytes is set
	always_comb
	begin
		for (int i = 0; i < 8; i++)
		begin
			zero_flags[i] = 1'b1;
			for (int j = 0; j < 8; j++)
				if (((j >> size) == (i >> size)) && (a[8 * j +: 8] != 8'd0))
					zero_flags[i] = 1'b0;
		end
	end

	always_comb
	begin
		case (sel)
		simd_alu_pkg::sel_sum: next_result = sum;
		simd_alu_pkg::sel_diff: next_result = diff;
		simd_alu_pkg::sel_ltu: next_result = expand_flags(ltu_flags, size);
		simd_alu_pkg::sel_lts: next_result = expand_flags(lts_flags, size);
		simd_alu_pkg::sel_and: next_result = a & b;
		simd_alu_pkg::sel_orr: next_result = a | b;
		simd_alu_pkg::sel_xor: next_result = a ^ b;
		simd_alu_pkg::sel_inv: next_result = ~a;
		simd_alu_pkg::sel_not: next_result = expand_flags(zero_flags, size);
		simd_alu_pkg::sel_shl: next_result = shl;
		simd_alu_pkg::sel_lsr: next_result = lsr;
		simd_alu_pkg::sel_asr: next_result = asr;
		default: next_result = '0;
		endcase
	end

	// holds between starts
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			result <= '0;
		else if (load)
			result <= next_result;
	end

endmodule

// ==== source/simd_alu.sv ====
`timescale 1ns/10ps

module simd_alu
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input simd_alu_pkg::alu_req_t req,
	output simd_alu_pkg::word_t result,
	output logic done
);

	simd_alu_pkg::result_sel_e sel;
	logic load;
	simd_alu_pkg::word_t sum;
	simd_alu_pkg::word_t diff;
	simd_alu_pkg::lane_flags_t ltu_flags;
	simd_alu_pkg::lane_flags_t lts_flags;
	simd_alu_pkg::word_t shl;
	simd_alu_pkg::word_t lsr;
	simd_alu_pkg::word_t asr;

	alu_control i_alu_control
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(req.op),
		.is_signed(req.is_signed),
		.sel(sel),
		.load(load),
		.done(done)
	);

	lane_adder i_lane_adder
	(
		.a(req.a),
		.b(req.b),
		.size(req.size),
		.sum(sum),
		.diff(diff),
		.ltu_flags(ltu_flags),
		.lts_flags(lts_flags)
	);

	lane_shifter i_lane_shifter
	(
		.a(req.a),
		.b(req.b),
		.size(req.size),
		.shl(shl),
		.lsr(lsr),
		.asr(asr)
	);

	result_select i_result_select
	(
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.sel(sel),
		.size(req.size),
		.a(req.a),
		.b(req.b),
		.sum(sum),
		.diff(diff),
		.ltu_flags(ltu_flags),
		.lts_flags(lts_flags),
		.shl(shl),
		.lsr(lsr),
		.asr(asr),
		.result(result)
	);

endmodule

// ==== source/simd_alu_pkg.sv ====
package simd_alu_pkg;

	typedef logic [63:0] word_t;

	// lane width of one operation
	typedef enum logic [1:0]
	{
		size_8 = 2'd0,
		size_16 = 2'd1,
		size_32 = 2'd2,
		size_64 = 2'd3
	} lane_size_e;

	// codes 4'ha to 4'hf are illegal
	typedef enum logic [3:0]
	{
		op_add = 4'h0,
		op_sub = 4'h1,
		op_slt = 4'h2,
		op_and = 4'h3,
		op_orr = 4'h4,
		op_xor = 4'h5,
		op_shl = 4'h6,
		op_shr = 4'h7,
		op_inv = 4'h8,
		op_not = 4'h9
	} alu_op_e;

	typedef struct packed
	{
		word_t a;
		word_t b;
		alu_op_e op;
		lane_size_e size;
		logic is_signed;
	} alu_req_t;

	typedef enum logic [3:0]
	{
		sel_sum, sel_diff, sel_ltu, sel_lts, sel_and, sel_orr, sel_xor,
		sel_inv, sel_not, sel_shl, sel_lsr, sel_asr, sel_zero
	} result_sel_e;

	// one flag per byte, a lane's flag sits at its lowest byte
	typedef logic [7:0] lane_flags_t;

	// top bit of every lane cleared, stops carries at lane edges
	localparam word_t LANE_LOW_MASK_8 = 64'h7f7f_7f7f_7f7f_7f7f;
	localparam word_t LANE_LOW_MASK_16 = 64'h7fff_7fff_7fff_7fff;
	localparam word_t LANE_LOW_MASK_32 = 64'h7fff_ffff_7fff_ffff;
	localparam word_t LANE_LOW_MASK_64 = 64'h7fff_ffff_ffff_ffff;

	function automatic word_t lane_low_mask(lane_size_e size);
		word_t mask;
		case (size)
		size_8: mask = LANE_LOW_MASK_8;
		size_16: mask = LANE_LOW_MASK_16;
		size_32: mask = LANE_LOW_MASK_32;
		default: mask = LANE_LOW_MASK_64;
		endcase
		return mask;
	endfunction

endpackage

// ==== src.f ====
source/simd_alu_pkg.sv
source/alu_control.sv
source/lane_adder.sv
source/lane_shifter.sv
source/result_select.sv
source/simd_alu.sv
tests/simd_alu_checker.sv
tests/simd_alu_tb.sv

// ==== tests/simd_alu_checker.sv ====
`timescale 1ns/10ps

module simd_alu_checker
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input simd_alu_pkg::alu_req_t req,
	input simd_alu_pkg::word_t result,
	input logic done
);

	int fail_count = 0;
	simd_alu_pkg::word_t exp_result;

	// lane by lane model of the instruction rules
	function automatic simd_alu_pkg::word_t model(simd_alu_pkg::alu_req_t r);
		int w;
		logic [63:0] mask;
		logic [63:0] la;
		logic [63:0] lb;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] lane;
		simd_alu_pkg::word_t out;
		w = 8 << r.size;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		out = '0;
		for (int l = 0; l < 64 / w; l++)
		begin
			la = (r.a >> (w * l)) & mask;
			lb = (r.b >> (w * l)) & mask;
			// sign extended copies for the signed forms
			sa = la[w - 1] ? (la | ~mask) : la;
			sb = lb[w - 1] ? (lb | ~mask) : lb;
			case (r.op)
			simd_alu_pkg::op_add: lane = la + lb;
			simd_alu_pkg::op_sub: lane = la - lb;
			simd_alu_pkg::op_slt: lane = {63'd0, r.is_signed ? (sa < sb) : (la < lb)};
			simd_alu_pkg::op_and: lane = la & lb;
			simd_alu_pkg::op_orr: lane = la | lb;
			simd_alu_pkg::op_xor: lane = la ^ lb;
			simd_alu_pkg::op_inv: lane = ~la;
			simd_alu_pkg::op_not: lane = {63'd0, la == 64'd0};
			simd_alu_pkg::op_shl: lane = (lb < 64'(w)) ? (la << lb) : '0;
			simd_alu_pkg::op_shr:
			begin
				if (!r.is_signed)
					lane = (lb < 64'(w)) ? (la >> lb) : '0;
				else
					lane = sa >>> ((lb < 64'(w)) ? lb : 64'(w - 1));
			end
			default: lane = '0;
			endcase
			out |= (lane & mask) << (w * l);
		end
		return out;
	endfunction

	// answer due on the cycle after each start
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			exp_result <= '0;
		else if (start)
			exp_result <= model(req);
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		start |=> result == exp_result)
	else
	begin
		fail_count++;
		$error("FAIL %0t: result %h, expected %h", $time, $sampled(result),
			$sampled(exp_result));
	end

	a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		start |=> done)
	else
	begin
		fail_count++;
		$error("FAIL %0t: done missing in the cycle after start", $time);
	end

	a_no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
		!start |=> !done)
	else
	begin
		fail_count++;
		$error("FAIL %0t: done high without a start", $time);
	end

	a_result_holds: assert property (@(posedge clk) disable iff (!rst_n)
		!start |=> $stable(result))
	else
	begin
		fail_count++;
		$error("FAIL %0t: result changed without a start", $time);
	end

	a_reset_values: assert property (@(posedge clk)
		$rose(rst_n) |-> !done && result == '0)
	else
	begin
		fail_count++;
		$error("FAIL %0t: done or result not zero after reset", $time);
	end

endmodule

// ==== tests/simd_alu_tb.sv ====
`timescale 1ns/10ps

module simd_alu_tb;

	localparam int DONE_TIMEOUT = 10;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	simd_alu_pkg::alu_req_t req;
	simd_alu_pkg::word_t result;
	logic done;

	logic [63:0] lcg_state = 64'd61;
	int timeouts = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int fails_before = 0;
	string test_name;

	simd_alu i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.req(req),
		.result(result),
		.done(done)
	);

	bind simd_alu simd_alu_checker i_checker
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.req(req),
		.result(result),
		.done(done)
	);

	always #2 clk = ~clk;

	function automatic logic [63:0] lcg_next();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	// upper halves only since the low LCG bits repeat quickly
	function automatic simd_alu_pkg::word_t rand_word();
		logic [63:0] hi;
		logic [63:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[63:32], lo[63:32]};
	endfunction

	// 1 in the lowest bit of every lane
	function automatic simd_alu_pkg::word_t lane_lsbs(simd_alu_pkg::lane_size_e size);
		simd_alu_pkg::word_t w;
		w = '0;
		for (int i = 0; i < 64; i += (8 << size))
			w[i] = 1'b1;
		return w;
	endfunction

	// unrelated request on the bus while start is low
	function automatic simd_alu_pkg::alu_req_t idle_req();
		simd_alu_pkg::alu_req_t r;
		r.a = rand_word();
		r.b = rand_word();
		r.op = simd_alu_pkg::op_xor;
		r.size = simd_alu_pkg::size_8;
		r.is_signed = 1'b0;
		return r;
	endfunction

	task automatic begin_test(string name);
		test_name = name;
		fails_before = i_dut.i_checker.fail_count + timeouts;
	endtask

	task automatic end_test();
		int new_fails;
		new_fails = i_dut.i_checker.fail_count + timeouts - fails_before;
		tests_run++;
		if (new_fails != 0)
			tests_failed++;
		$display("%s: %0d failures", test_name, new_fails);
	endtask

	task automatic issue(simd_alu_pkg::alu_op_e op, simd_alu_pkg::lane_size_e size,
		logic is_signed, simd_alu_pkg::word_t a, simd_alu_pkg::word_t b);
		int waited;
		@(negedge clk);
		start = 1'b1;
		req = '{a: a, b: b, op: op, size: size, is_signed: is_signed};
		@(negedge clk);
		start = 1'b0;
		req = idle_req();
		waited = 0;
		while (!done && waited < DONE_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!done)
		begin
			timeouts++;
			$display("Test %s timed out waiting for done.", test_name);
		end
	endtask

	initial
	begin
		simd_alu_pkg::lane_size_e sz;
		simd_alu_pkg::word_t x;
		simd_alu_pkg::word_t top;
		simd_alu_pkg::word_t keep;
		int wdt;
		int k;
		int waited;
		rst_n = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		begin_test("add_sub");
		for (int s = 0; s < 4; s++)
		begin
			sz = simd_alu_pkg::lane_size_e'(s);
			top = lane_lsbs(sz) << ((8 << s) - 1);
			for (int i = 0; i < 6; i++)
			begin
				issue(simd_alu_pkg::op_add, sz, 1'b0, rand_word(), rand_word());
				issue(simd_alu_pkg::op_sub, sz, 1'b0, rand_word(), rand_word());
			end
			// every lane wraps
			issue(simd_alu_pkg::op_add, sz, 1'b0, '1, lane_lsbs(sz));
			issue(simd_alu_pkg::op_add, sz, 1'b0, top, top);
			issue(simd_alu_pkg::op_sub, sz, 1'b0, '0, lane_lsbs(sz));
			issue(simd_alu_pkg::op_sub, sz, 1'b0, top, ~top);
		end
		end_test();

		begin_test("set_less_than");
		for (int s = 0; s < 4; s++)
		begin
			sz = simd_alu_pkg::lane_size_e'(s);
			top = lane_lsbs(sz) << ((8 << s) - 1);
			for (int sg = 0; sg < 2; sg++)
			begin
				x = rand_word();
				issue(simd_alu_pkg::op_slt, sz, sg[0], rand_word(), rand_word());
				issue(simd_alu_pkg::op_slt, sz, sg[0], rand_word(), rand_word());
				issue(simd_alu_pkg::op_slt, sz, sg[0], x, x);
				// opposite signs in every lane
				issue(simd_alu_pkg::op_slt, sz, sg[0], top, lane_lsbs(sz));
				issue(simd_alu_pkg::op_slt, sz, sg[0], lane_lsbs(sz), top);
				issue(simd_alu_pkg::op_slt, sz, sg[0], x, x ^ top);
			end
		end
		end_test();

		begin_test("shift");
		for (int s = 0; s < 4; s++)
		begin
			sz = simd_alu_pkg::lane_size_e'(s);
			wdt = 8 << s;
			top = lane_lsbs(sz) << (wdt - 1);
			for (int i = 0; i < 5; i++)
			begin
				// two random amounts, then width - 1, width and width + 1
				k = (i < 2) ? int'(lcg_next() % 64'(wdt)) : wdt - 3 + i;
				x = rand_word();
				issue(simd_alu_pkg::op_shl, sz, 1'b0, x, lane_lsbs(sz) * 64'(k));
				issue(simd_alu_pkg::op_shr, sz, 1'b0, x, lane_lsbs(sz) * 64'(k));
				issue(simd_alu_pkg::op_shr, sz, 1'b1, x | top, lane_lsbs(sz) * 64'(k));
			end
			issue(simd_alu_pkg::op_shr, sz, 1'b1, rand_word(), rand_word());
		end
		end_test();

		begin_test("bitwise_not_illegal");
		for (int s = 0; s < 4; s++)
		begin
			sz = simd_alu_pkg::lane_size_e'(s);
			wdt = 8 << s;
			x = rand_word();
			issue(simd_alu_pkg::op_and, sz, 1'b0, x, rand_word());
			issue(simd_alu_pkg::op_orr, sz, 1'b0, x, rand_word());
			issue(simd_alu_pkg::op_xor, sz, 1'b0, x, rand_word());
			issue(simd_alu_pkg::op_inv, sz, 1'b0, x, rand_word());
			// some lanes of a forced to zero
			keep = (rand_word() & lane_lsbs(sz)) * ((64'd1 << wdt) - 64'd1);
			issue(simd_alu_pkg::op_not, sz, 1'b0, x & keep, x);
			issue(simd_alu_pkg::op_not, sz, 1'b0, '0, x);
		end
		for (int c = 10; c < 16; c++)
			issue(simd_alu_pkg::alu_op_e'(c), simd_alu_pkg::lane_size_e'(c % 4), c[0],
				rand_word(), rand_word());
		end_test();

		begin_test("timing");
		// back-to-back starts
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			start = 1'b1;
			req = '{a: rand_word(), b: rand_word(), op: simd_alu_pkg::alu_op_e'(i),
				size: simd_alu_pkg::lane_size_e'(i % 4), is_signed: i[0]};
		end
		@(negedge clk);
		start = 1'b0;
		req = idle_req();
		waited = 0;
		while (done && waited < DONE_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (done)
		begin
			timeouts++;
			$display("Test %s timed out waiting for done to fall.", test_name);
		end
		// idle cycles where result has to hold
		repeat (6) @(negedge clk);
		end_test();

		$display("tests %0d, failed %0d, assertion failures %0d, timeouts %0d",
			tests_run, tests_failed, i_dut.i_checker.fail_count, timeouts);
		if (tests_failed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
